//--- core_ctrl_top.f
+incdir+common
common/core_ctrl_pkg.sv
rtl/layer_shape_rom.sv
sequencer/layer_sequencer.sv
feed/fm_unpacker.sv
rtl/fm_buffer.sv
writeback/wb_packer.sv
rtl/core_ctrl_top.sv
dv/tb_clock_gen.sv
dv/tb_core_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module tb_core_ctrl \
    -f core_ctrl_top.f -o tb_core_ctrl &&
./obj_dir/tb_core_ctrl > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && exit 0 || exit 1

//--- dv/tb_core_ctrl.sv
// core control testbench
`timescale 1ns/1ps
`default_nettype none

module tb_core_ctrl;
    import core_ctrl_pkg::*;

    localparam int RUN_LIMIT  = 20000;
    localparam int WAIT_LIMIT = 50;

    logic     clk;
    logic     rst_n;
    logic     core_valid;
    logic     core_ready;
    logic     core_finish;
    logic     load_wr_en;
    fm_addr_t load_addr;
    fm_word_t load_din;
    fm_addr_t dump_addr;
    fm_word_t dump_data;
    logic     act_valid;
    fm_byte_t act_data;
    logic     act_ready;
    logic     wb_valid;
    fm_byte_t wb_data;
    logic     wb_ready;

    integer   seed;
    int       test_errs;
    int       tests_passed;
    int       tests_failed;
    int       finish_cnt;
    fm_word_t model_mem [0:15];
    fm_byte_t act_q [$];
    fm_byte_t wb_q [$];
    int       seg_q [$];
    int       in_words_tbl [1:5];
    int       wb_words_tbl [1:5];

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    core_ctrl_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_valid  (core_valid),
        .core_ready  (core_ready),
        .core_finish (core_finish),
        .load_wr_en  (load_wr_en),
        .load_addr   (load_addr),
        .load_din    (load_din),
        .dump_addr   (dump_addr),
        .dump_data   (dump_data),
        .act_valid   (act_valid),
        .act_data    (act_data),
        .act_ready   (act_ready),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .wb_ready    (wb_ready)
    );

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("ok   %s", name);
            tests_passed++;
        end else begin
            $display("fail %s (%0d errors)", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            tick();
            n++;
            if (n > WAIT_LIMIT) abort_run("reset was never released");
        end
        tick();
    endtask

    // four random words into half 0 and into the model
    task automatic load_half0();
        logic [95:0] rnd;
        for (int i = 0; i < 4; i++) begin
            tick();
            rnd = {$random(seed), $random(seed), $random(seed)};
            load_wr_en = 1'b1;
            load_addr  = fm_addr_t'(i);
            load_din   = rnd[71:0];
            model_mem[i] = rnd[71:0];
        end
        tick();
        load_wr_en = 1'b0;
    endtask

    task automatic start_core();
        int n;
        n = 0;
        tick();
        core_valid = 1'b1;
        do begin
            tick();
            n++;
            if (n > WAIT_LIMIT) abort_run("core never accepted the start request");
        end while (core_ready);
        core_valid = 1'b0;
    endtask

    // random stalls on both streams with bytes sampled at the falling edge
    task automatic run_layers();
        int          cycles;
        int          tail;
        int          seg_cnt;
        logic        hold_wb;
        logic        prev_ready;
        logic [31:0] rnd;
        act_q.delete();
        wb_q.delete();
        seg_q.delete();
        finish_cnt = 0;
        seg_cnt    = 0;
        prev_ready = 1'b0;
        cycles     = 0;
        tail       = -1;
        while (tail != 0) begin
            @(negedge clk);
            if (act_valid && act_ready) act_q.push_back(act_data);
            hold_wb = wb_valid && !wb_ready;
            if (wb_valid && wb_ready) begin
                wb_q.push_back(wb_data);
                seg_cnt++;
            end
            // wb_ready falls at the end of each write-back layer
            if (prev_ready && !wb_ready) begin
                seg_q.push_back(seg_cnt);
                seg_cnt = 0;
            end
            prev_ready = wb_ready;
            if (core_finish) begin
                finish_cnt++;
                if (tail < 0) tail = 6;
            end
            if (tail > 0) tail--;
            cycles++;
            if (cycles > RUN_LIMIT) abort_run("timeout waiting for core_finish");
            tick();
            rnd       = $random(seed);
            act_ready = (rnd[1:0] != 2'b00);
            if (hold_wb) begin
                wb_valid = 1'b1;
            end else begin
                wb_valid = (rnd[3:2] != 2'b00);
                wb_data  = rnd[15:8];
            end
        end
        act_ready = 1'b0;
        wb_valid  = 1'b0;
    endtask

    // odd layers read half 0 and bytes come msb first
    task automatic compare_layer(input int k, input string name, inout int pos);
        int       base;
        fm_word_t word;
        fm_byte_t exp_b;
        logic     bad;
        base = (k % 2 == 1) ? 0 : 8;
        bad  = 1'b0;
        for (int w = 0; w < in_words_tbl[k]; w++) begin
            word = model_mem[base + w];
            for (int b = 0; b < 9; b++) begin
                exp_b = word[71 - 8*b -: 8];
                if (pos >= act_q.size()) begin
                    if (!bad) $display("%s: layer %0d stream ended early", name, k);
                    bad = 1'b1;
                    test_errs++;
                end else if (act_q[pos] !== exp_b && !bad) begin
                    $display("** Error %s: layer %0d byte %0d expected %h, actual %h",
                             name, k, pos, exp_b, act_q[pos]);
                    bad = 1'b1;
                    test_errs++;
                end
                pos++;
            end
        end
    endtask

    // odd layers write half 1 and the first byte lands on top
    task automatic apply_writeback(input int k, inout int pos);
        int       base;
        fm_word_t word;
        base = (k % 2 == 1) ? 8 : 0;
        for (int w = 0; w < wb_words_tbl[k]; w++) begin
            word = '0;
            for (int b = 0; b < 9; b++) begin
                if (pos < wb_q.size()) word = {word[63:0], wb_q[pos]};
                pos++;
            end
            model_mem[base + w] = word;
        end
    endtask

    task automatic check_run(input int run);
        int    pos_a;
        int    pos_w;
        string name;
        pos_a = 0;
        pos_w = 0;
        name  = $sformatf("layer-1 stream, run %0d", run);
        compare_layer(1, name, pos_a);
        end_test(name);
        apply_writeback(1, pos_w);

        name = $sformatf("layer chaining, run %0d", run);
        for (int k = 2; k <= 5; k++) begin
            compare_layer(k, name, pos_a);
            apply_writeback(k, pos_w);
        end
        end_test(name);

        name = $sformatf("back-pressure, run %0d", run);
        if (act_q.size() != 180) begin
            $display("** Error %s: act bytes expected 180, actual %0d", name, act_q.size());
            test_errs++;
        end
        if (seg_q.size() != 5) begin
            $display("** Error %s: wb layers expected 5, actual %0d", name, seg_q.size());
            test_errs++;
        end
        for (int k = 1; k <= 5 && k <= seg_q.size(); k++) begin
            if (seg_q[k-1] != 9 * wb_words_tbl[k]) begin
                $display("** Error %s: layer %0d wb bytes expected %0d, actual %0d",
                         name, k, 9 * wb_words_tbl[k], seg_q[k-1]);
                test_errs++;
            end
        end
        end_test(name);

        name = $sformatf("completion, run %0d", run);
        if (finish_cnt != 1) begin
            $display("** Error %s: finish pulses expected 1, actual %0d", name, finish_cnt);
            test_errs++;
        end
        if (core_ready !== 1'b1) begin
            $display("** Error %s: core_ready expected 1, actual %b", name, core_ready);
            test_errs++;
        end
        for (int a = 8; a < 10; a++) begin
            tick();
            dump_addr = fm_addr_t'(a);
            tick();
            if (dump_data !== model_mem[a]) begin
                $display("** Error %s: word %0d expected %h, actual %h",
                         name, a, model_mem[a], dump_data);
                test_errs++;
            end
        end
        end_test(name);
    endtask

    initial begin
        core_valid = 1'b0;
        load_wr_en = 1'b0;
        load_addr  = '0;
        load_din   = '0;
        dump_addr  = '0;
        act_ready  = 1'b0;
        wb_valid   = 1'b0;
        wb_data    = '0;
        seed         = 32'h484e_81d6;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        in_words_tbl = '{4, 6, 5, 3, 2};
        wb_words_tbl = '{6, 5, 3, 2, 2};

        wait_reset();
        if (core_ready !== 1'b1) begin
            $display("** Error reset values: core_ready expected 1, actual %b", core_ready);
            test_errs++;
        end
        if (core_finish !== 1'b0) begin
            $display("** Error reset values: core_finish expected 0, actual %b", core_finish);
            test_errs++;
        end
        if (act_valid !== 1'b0) begin
            $display("** Error reset values: act_valid expected 0, actual %b", act_valid);
            test_errs++;
        end
        if (wb_ready !== 1'b0) begin
            $display("** Error reset values: wb_ready expected 0, actual %b", wb_ready);
            test_errs++;
        end
        end_test("reset values");

        for (int run = 1; run <= 2; run++) begin
            load_half0();
            start_core();
            run_layers();
            check_run(run);
        end

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/core_ctrl_top.sv
// convolution core control top
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    core_valid,
    output logic                    core_ready,
    output logic                    core_finish,
    input  logic                    load_wr_en,
    input  core_ctrl_pkg::fm_addr_t load_addr,
    input  core_ctrl_pkg::fm_word_t load_din,
    input  core_ctrl_pkg::fm_addr_t dump_addr,
    output core_ctrl_pkg::fm_word_t dump_data,
    output logic                    act_valid,
    output core_ctrl_pkg::fm_byte_t act_data,
    input  logic                    act_ready,
    input  logic                    wb_valid,
    input  core_ctrl_pkg::fm_byte_t wb_data,
    output logic                    wb_ready
);
    import core_ctrl_pkg::*;

    layer_num_t in_layer;
    layer_num_t wb_layer;
    word_cnt_t  in_words;
    word_cnt_t  wb_words;
    logic       in_start;
    logic       wb_start;
    logic       in_done;
    logic       wb_done;
    logic       busy;
    logic       rd_en;
    fm_addr_t   rd_addr;
    fm_word_t   rd_data;
    logic       pk_wr_en;
    fm_addr_t   pk_addr;
    fm_word_t   pk_din;

    layer_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .core_valid  (core_valid),
        .core_ready  (core_ready),
        .core_finish (core_finish),
        .in_done     (in_done),
        .wb_done     (wb_done),
        .in_start    (in_start),
        .wb_start    (wb_start),
        .busy        (busy),
        .in_layer    (in_layer),
        .wb_layer    (wb_layer)
    );

    // input and write-back may be on different layers
    layer_shape_rom u_in_rom (
        .layer    (in_layer),
        .in_words (in_words),
        .wb_words ()
    );

    layer_shape_rom u_wb_rom (
        .layer    (wb_layer),
        .in_words (),
        .wb_words (wb_words)
    );

    fm_unpacker u_unpack (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_start  (in_start),
        .in_layer  (in_layer),
        .in_words  (in_words),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .act_valid (act_valid),
        .act_data  (act_data),
        .act_ready (act_ready),
        .in_done   (in_done)
    );

    fm_buffer u_buf (
        .clk        (clk),
        .busy       (busy),
        .load_wr_en (load_wr_en),
        .load_addr  (load_addr),
        .load_din   (load_din),
        .dump_addr  (dump_addr),
        .dump_data  (dump_data),
        .pk_wr_en   (pk_wr_en),
        .pk_addr    (pk_addr),
        .pk_din     (pk_din),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    wb_packer u_pack (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_start (wb_start),
        .wb_layer (wb_layer),
        .wb_words (wb_words),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .wb_ready (wb_ready),
        .pk_wr_en (pk_wr_en),
        .pk_addr  (pk_addr),
        .pk_din   (pk_din),
        .wb_done  (wb_done)
    );

endmodule

`default_nettype wire

//--- writeback/wb_packer.sv
// result byte packer
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defines.svh"

module wb_packer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wb_start,
    input  core_ctrl_pkg::layer_num_t wb_layer,
    input  core_ctrl_pkg::word_cnt_t  wb_words,
    input  logic                      wb_valid,
    input  core_ctrl_pkg::fm_byte_t   wb_data,
    output logic                      wb_ready,
    output logic                      pk_wr_en,
    output core_ctrl_pkg::fm_addr_t   pk_addr,
    output core_ctrl_pkg::fm_word_t   pk_din,
    output logic                      wb_done
);
    import core_ctrl_pkg::*;

    localparam int         SHIFT_W   = (`CORE_BYTES_PER_WORD - 1) * `CORE_BYTE_W;
    localparam logic [3:0] BYTE_LAST = 4'(`CORE_BYTES_PER_WORD - 1);

    logic [SHIFT_W-1:0] shift_q;
    logic [3:0]         byte_cnt;
    word_cnt_t          word_idx;
    logic               active;
    logic               fire;
    logic               word_full;
    logic               last_word;

    assign wb_ready  = active;
    assign fire      = wb_valid && wb_ready;
    assign word_full = (byte_cnt == BYTE_LAST);
    assign last_word = (word_idx == wb_words - 1'b1);

    // ninth byte goes straight into the low lane of the written word
    assign pk_wr_en = fire && word_full;
    assign pk_din   = {shift_q, wb_data};

    // odd layers write half 1, even layers half 0
    assign pk_addr = {wb_layer[0], word_idx[`CORE_FM_ADDR_W-2:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            byte_cnt <= '0;
            word_idx <= '0;
            wb_done  <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            if (wb_start) begin
                active   <= 1'b1;
                byte_cnt <= '0;
                word_idx <= '0;
            end else if (fire) begin
                if (word_full) begin
                    byte_cnt <= '0;
                    word_idx <= word_idx + 1'b1;
                    if (last_word) begin
                        active  <= 1'b0;
                        wb_done <= 1'b1;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // earlier bytes move toward the top
    always_ff @(posedge clk) begin
        if (fire) shift_q <= {shift_q[SHIFT_W-`CORE_BYTE_W-1:0], wb_data};
    end

    a_write_in_layer: assert property (@(posedge clk) disable iff (!rst_n)
        pk_wr_en |-> (wb_layer != '0) && (word_idx < wb_words))
        else $error("buffer write outside an active write-back layer");

endmodule

`default_nettype wire

//--- rtl/fm_buffer.sv
// feature-map buffer
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defines.svh"

module fm_buffer (
    input  logic                    clk,
    input  logic                    busy,
    input  logic                    load_wr_en,
    input  core_ctrl_pkg::fm_addr_t load_addr,
    input  core_ctrl_pkg::fm_word_t load_din,
    input  core_ctrl_pkg::fm_addr_t dump_addr,
    output core_ctrl_pkg::fm_word_t dump_data,
    input  logic                    pk_wr_en,
    input  core_ctrl_pkg::fm_addr_t pk_addr,
    input  core_ctrl_pkg::fm_word_t pk_din,
    input  logic                    rd_en,
    input  core_ctrl_pkg::fm_addr_t rd_addr,
    output core_ctrl_pkg::fm_word_t rd_data
);
    import core_ctrl_pkg::*;

    fm_word_t mem [0:`CORE_FM_DEPTH-1];
    fm_word_t rd_q;
    logic     wr_en_mux;
    fm_addr_t wr_addr_mux;
    fm_word_t wr_din_mux;
    logic     rd_en_mux;
    fm_addr_t rd_addr_mux;

    // host owns both ports while idle
    always_comb begin
        if (busy) begin
            wr_en_mux   = pk_wr_en;
            wr_addr_mux = pk_addr;
            wr_din_mux  = pk_din;
            rd_en_mux   = rd_en;
            rd_addr_mux = rd_addr;
        end else begin
            wr_en_mux   = load_wr_en;
            wr_addr_mux = load_addr;
            wr_din_mux  = load_din;
            rd_en_mux   = 1'b1;
            rd_addr_mux = dump_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_mux) mem[wr_addr_mux] <= wr_din_mux;
        if (rd_en_mux) rd_q <= mem[rd_addr_mux];
    end

    // one read register serves both dump and unpacker
    assign rd_data   = rd_q;
    assign dump_data = rd_q;

endmodule

`default_nettype wire

//--- feed/fm_unpacker.sv
// feature-map word unpacker
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defines.svh"

module fm_unpacker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_start,
    input  core_ctrl_pkg::layer_num_t in_layer,
    input  core_ctrl_pkg::word_cnt_t  in_words,
    output logic                      rd_en,
    output core_ctrl_pkg::fm_addr_t   rd_addr,
    input  core_ctrl_pkg::fm_word_t   rd_data,
    output logic                      act_valid,
    output core_ctrl_pkg::fm_byte_t   act_data,
    input  logic                      act_ready,
    output logic                      in_done
);
    import core_ctrl_pkg::*;

    localparam logic [3:0] BYTE_LAST = 4'(`CORE_BYTES_PER_WORD - 1);

    fm_word_t   shift_q;
    logic [3:0] byte_cnt;
    word_cnt_t  word_idx;
    logic       fetch_q;
    logic       fire;
    logic       last_byte;

    assign fire      = act_valid && act_ready;
    assign last_byte = (byte_cnt == BYTE_LAST);

    // odd layers read half 0, even layers half 1
    assign rd_addr = {~in_layer[0], word_idx[`CORE_FM_ADDR_W-2:0]};

    assign act_data = shift_q[$bits(fm_word_t)-1 -: `CORE_BYTE_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en     <= 1'b0;
            fetch_q   <= 1'b0;
            act_valid <= 1'b0;
            byte_cnt  <= '0;
            word_idx  <= '0;
            in_done   <= 1'b0;
        end else begin
            rd_en   <= 1'b0;
            in_done <= 1'b0;
            fetch_q <= rd_en;
            if (in_start) begin
                word_idx <= '0;
                rd_en    <= 1'b1;
            end
            // buffer data arrives the cycle after the read
            if (fetch_q) begin
                act_valid <= 1'b1;
                byte_cnt  <= '0;
            end else if (fire) begin
                if (last_byte) begin
                    act_valid <= 1'b0;
                    byte_cnt  <= '0;
                    if (word_idx == in_words - 1'b1) begin
                        in_done <= 1'b1;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                        rd_en    <= 1'b1;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // msb first, shift left on every accepted byte
    always_ff @(posedge clk) begin
        if (fetch_q) shift_q <= rd_data;
        else if (fire) shift_q <= shift_q << `CORE_BYTE_W;
    end

    a_act_hold: assert property (@(posedge clk) disable iff (!rst_n)
        act_valid && !act_ready |=> act_valid && $stable(act_data))
        else $error("activation byte changed during a stall");

endmodule

`default_nettype wire

//--- sequencer/layer_sequencer.sv
// layer sequencer
`timescale 1ns/1ps
`default_nettype none

`include "core_ctrl_defines.svh"

module layer_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      core_valid,
    output logic                      core_ready,
    output logic                      core_finish,
    input  logic                      in_done,
    input  logic                      wb_done,
    output logic                      in_start,
    output logic                      wb_start,
    output logic                      busy,
    output core_ctrl_pkg::layer_num_t in_layer,
    output core_ctrl_pkg::layer_num_t wb_layer
);
    import core_ctrl_pkg::*;

    layer_state_t in_state;
    layer_state_t in_state_nxt;
    layer_state_t wb_state;
    layer_state_t wb_state_nxt;
    logic         accept;
    logic         in_go;
    logic         wb_go;
    logic         in_last;
    logic         wb_last;
    logic         all_done;

    // same stepping for both machines
    function automatic layer_state_t step(layer_state_t cur, logic acc, logic go,
                                          logic done, logic last, logic fin);
        layer_state_t nxt;
        nxt = cur;
        case (cur)
            IDLE:       if (acc) nxt = START;
            START:      if (go) nxt = PROCESS;
            PROCESS: begin
                if (last) nxt = FINISH;
                else if (done) nxt = LAYER_DONE;
            end
            LAYER_DONE: nxt = START;
            FINISH:     if (fin) nxt = IDLE;
            default:    nxt = IDLE;
        endcase
        return nxt;
    endfunction

    assign accept = core_valid && core_ready;

    // input waits for the previous layer's write-back, write-back waits for input
    assign in_go = (in_state == START) && (wb_layer >= in_layer);
    assign wb_go = (wb_state == START) && (in_layer >= wb_layer);

    assign in_last = in_done && (in_layer == layer_num_t'(`CORE_NUM_LAYERS));
    assign wb_last = wb_done && (wb_layer == layer_num_t'(`CORE_NUM_LAYERS));

    // both sides must be through the last layer
    assign all_done = (in_state == FINISH || in_last) &&
                      (wb_state == FINISH || wb_last) && !core_finish;

    assign in_state_nxt = step(in_state, accept, in_go, in_done, in_last, core_finish);
    assign wb_state_nxt = step(wb_state, accept, wb_go, wb_done, wb_last, core_finish);

    assign busy = (in_state != IDLE) || (wb_state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_state <= IDLE;
            wb_state <= IDLE;
            in_start <= 1'b0;
            wb_start <= 1'b0;
        end else begin
            in_state <= in_state_nxt;
            wb_state <= wb_state_nxt;
            in_start <= in_go;
            wb_start <= wb_go;
        end
    end

    // layer counters step on each finished layer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_layer <= '0;
            wb_layer <= '0;
        end else if (accept) begin
            in_layer <= layer_num_t'(1);
            wb_layer <= layer_num_t'(1);
        end else if (core_finish) begin
            in_layer <= '0;
            wb_layer <= '0;
        end else begin
            if (in_done && !in_last) in_layer <= in_layer + 1'b1;
            if (wb_done && !wb_last) wb_layer <= wb_layer + 1'b1;
        end
    end

    // host handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_ready  <= 1'b1;
            core_finish <= 1'b0;
        end else begin
            core_finish <= all_done;
            if (accept) core_ready <= 1'b0;
            else if (core_finish) core_ready <= 1'b1;
        end
    end

    a_layer_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (in_layer <= wb_layer + 1) && (wb_layer <= in_layer + 1))
        else $error("input and write-back layers drifted apart");

    a_ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(core_ready && busy))
        else $error("core_ready high while a layer is running");

endmodule

`default_nettype wire

//--- rtl/layer_shape_rom.sv
// layer shape table
`timescale 1ns/1ps
`default_nettype none

module layer_shape_rom (
    input  core_ctrl_pkg::layer_num_t layer,
    output core_ctrl_pkg::word_cnt_t  in_words,
    output core_ctrl_pkg::word_cnt_t  wb_words
);
    import core_ctrl_pkg::*;

    // each layer reads what the one before it wrote
    always_comb begin
        case (layer)
            3'd1: begin
                in_words = word_cnt_t'(4);
                wb_words = word_cnt_t'(6);
            end
            3'd2: begin
                in_words = word_cnt_t'(6);
                wb_words = word_cnt_t'(5);
            end
            3'd3: begin
                in_words = word_cnt_t'(5);
                wb_words = word_cnt_t'(3);
            end
            3'd4: begin
                in_words = word_cnt_t'(3);
                wb_words = word_cnt_t'(2);
            end
            3'd5: begin
                in_words = word_cnt_t'(2);
                wb_words = word_cnt_t'(2);
            end
            // no layer selected
            default: begin
                in_words = '0;
                wb_words = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- common/core_ctrl_pkg.sv
// core control shared types
`default_nettype none

`include "core_ctrl_defines.svh"

package core_ctrl_pkg;

    // layer index, 1 to CORE_NUM_LAYERS while running
    typedef logic [`CORE_LAYER_W-1:0] layer_num_t;

    typedef logic [`CORE_WORD_CNT_W-1:0] word_cnt_t;

    typedef logic [`CORE_BYTE_W-1:0] fm_byte_t;

    // first byte of a word sits in the top lane
    typedef logic [`CORE_BYTES_PER_WORD*`CORE_BYTE_W-1:0] fm_word_t;

    // top bit picks the half
    typedef logic [`CORE_FM_ADDR_W-1:0] fm_addr_t;

    // states of the input and write-back machines
    typedef enum logic [2:0] {
        IDLE,
        START,
        PROCESS,
        LAYER_DONE,
        FINISH
    } layer_state_t;

endpackage

`default_nettype wire

//--- common/core_ctrl_defines.svh
// core control parameters
`ifndef CORE_CTRL_DEFINES_SVH
`define CORE_CTRL_DEFINES_SVH

// layers in one run of the core
`define CORE_NUM_LAYERS 5

// packing of the feature-map buffer
`define CORE_BYTES_PER_WORD 9
`define CORE_BYTE_W 8

// buffer geometry, two halves of eight words
`define CORE_FM_DEPTH 16
`define CORE_FM_ADDR_W 4

// layer index, zero means no layer
`define CORE_LAYER_W 3

// words read or written per layer
`define CORE_WORD_CNT_W 4

`endif
